/* l1_cache_consts.svh */
`ifndef L1_CACHE_CONSTS_SVH
`define L1_CACHE_CONSTS_SVH

// Word address width.
// The CPU and DRAM are word addressed.
`define L1_ADDR_W 16

// Width of one data word, which is also one line.
`define L1_DATA_W 32

// Line index width, taken from the low address bits.
`define L1_INDEX_W 4

// Tag width, the address bits above the index.
`define L1_TAG_W 12

// Number of lines in the direct-mapped array.
`define L1_LINES 16

`endif

/* l1_cache_pkg.sv */
`default_nettype none

`include "l1_cache_consts.svh"

package l1_cache_pkg;

	typedef logic [`L1_ADDR_W-1:0]  addr_t;
	typedef logic [`L1_DATA_W-1:0]  word_t;
	typedef logic [`L1_INDEX_W-1:0] index_t;
	typedef logic [`L1_TAG_W-1:0]   tag_t;

	// Controller states.
	typedef enum logic [3:0] {
		idle,
		read,
		read_miss,
		read_mem,
		read_data,
		write,
		write_hit,
		write_miss,
		write_mem,
		write_data,
		write_back,
		write_back_mem
	} cache_state_t;

	// Request from the CPU, held until ack.
	typedef struct packed {
		logic  cs;
		logic  we;
		addr_t addr;
		word_t wdata;
	} cpu_req_t;

	// Request to DRAM, held until dram_ack.
	typedef struct packed {
		logic  cs;
		logic  we;
		addr_t addr;
		word_t wdata;
	} dram_req_t;

	// Tag store result for the current index.
	typedef struct packed {
		logic hit;
		logic valid;
		logic dirty;
	} lookup_t;

	// Array write controls from the controller.
	typedef struct packed {
		logic sram_we;
		logic dirty_o;
		logic fill;
		logic tag_we;
	} array_ctrl_t;

endpackage

`default_nettype wire

/* l1_cache_controller.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_consts.svh"

module l1_cache_controller (
	input  wire                       clk,
	input  wire                       rst,
	input  wire l1_cache_pkg::cpu_req_t cpu_req,
	output logic                      ack,
	output l1_cache_pkg::word_t       rdata,
	output l1_cache_pkg::index_t      index,
	output l1_cache_pkg::tag_t        req_tag,
	input  wire l1_cache_pkg::lookup_t  lookup,
	input  wire l1_cache_pkg::tag_t     victim_tag,
	input  wire l1_cache_pkg::word_t    line_data,
	output l1_cache_pkg::array_ctrl_t ctrl,
	output l1_cache_pkg::dram_req_t   dram_req,
	input  wire                       dram_ack,
	input  wire l1_cache_pkg::word_t    dram_rdata
);

	l1_cache_pkg::cache_state_t state;
	l1_cache_pkg::cache_state_t next_state;
	l1_cache_pkg::addr_t        addr_q;
	l1_cache_pkg::word_t        wdata_q;
	l1_cache_pkg::word_t        rdata_q;
	logic                       ack_q;
	logic                       accept;
	logic                       hit_valid;
	logic                       victim_dirty;
	logic                       wb_sel;

	// A request still high in its own ack cycle is not a new one.
	assign accept = (state == l1_cache_pkg::idle) && cpu_req.cs && !ack_q;

	assign hit_valid    = lookup.hit && lookup.valid;
	assign victim_dirty = lookup.valid && lookup.dirty && !lookup.hit;
	assign wb_sel       = (state == l1_cache_pkg::write_back_mem);

	assign index   = addr_q[`L1_INDEX_W-1:0];
	assign req_tag = addr_q[`L1_ADDR_W-1:`L1_INDEX_W];
	assign ack     = ack_q;
	assign rdata   = rdata_q;

	always_comb
	begin
		next_state = state;
		case (state)
			l1_cache_pkg::idle:
				if (accept)
					next_state = cpu_req.we ? l1_cache_pkg::write : l1_cache_pkg::read;
			l1_cache_pkg::read:
				if (hit_valid)
					next_state = l1_cache_pkg::idle;
				else if (victim_dirty)
					next_state = l1_cache_pkg::write_back;
				else
					next_state = l1_cache_pkg::read_miss;
			l1_cache_pkg::read_miss:
				next_state = l1_cache_pkg::read_mem;
			l1_cache_pkg::read_mem:
				if (dram_ack)
					next_state = l1_cache_pkg::read_data;
			l1_cache_pkg::read_data:
				next_state = l1_cache_pkg::idle;
			l1_cache_pkg::write:
				next_state = hit_valid ? l1_cache_pkg::write_hit : l1_cache_pkg::write_miss;
			l1_cache_pkg::write_hit:
				next_state = l1_cache_pkg::idle;
			l1_cache_pkg::write_miss:
				next_state = l1_cache_pkg::write_mem;
			l1_cache_pkg::write_mem:
				if (dram_ack)
					next_state = l1_cache_pkg::write_data;
			l1_cache_pkg::write_data:
				next_state = l1_cache_pkg::idle;
			l1_cache_pkg::write_back:
				next_state = l1_cache_pkg::write_back_mem;
			l1_cache_pkg::write_back_mem:
				// The victim is out, now fetch the requested word.
				if (dram_ack)
					next_state = l1_cache_pkg::read_miss;
			default:
				next_state = l1_cache_pkg::idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= l1_cache_pkg::idle;
			ack_q <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// Ack goes high for the cycle after a hit or a finished DRAM access.
			ack_q <= ((state == l1_cache_pkg::read) && hit_valid) ||
				((state == l1_cache_pkg::write) && hit_valid) ||
				((state == l1_cache_pkg::read_mem) && dram_ack) ||
				((state == l1_cache_pkg::write_mem) && dram_ack);
		end
	end

	// Request capture and read data.
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			addr_q  <= cpu_req.addr;
			wdata_q <= cpu_req.wdata;
		end
		if ((state == l1_cache_pkg::read) && hit_valid)
			rdata_q <= line_data;
		else if ((state == l1_cache_pkg::read_mem) && dram_ack)
			rdata_q <= dram_rdata;
	end

	always_comb
	begin
		ctrl        = '0;
		dram_req.cs = 1'b0;
		dram_req.we = 1'b0;
		case (state)
			l1_cache_pkg::read_data:
			begin
				// Fill the line from the registered DRAM word, clean.
				ctrl.sram_we = 1'b1;
				ctrl.tag_we  = 1'b1;
				ctrl.fill    = 1'b1;
			end
			l1_cache_pkg::write_hit:
			begin
				ctrl.sram_we = 1'b1;
				ctrl.tag_we  = 1'b1;
				ctrl.dirty_o = 1'b1;
			end
			l1_cache_pkg::read_mem:
				dram_req.cs = 1'b1;
			l1_cache_pkg::write_mem,
			l1_cache_pkg::write_back_mem:
			begin
				dram_req.cs = 1'b1;
				dram_req.we = 1'b1;
			end
			default:
				dram_req.cs = 1'b0;
		endcase
		dram_req.addr  = wb_sel ? {victim_tag, index} : addr_q;
		dram_req.wdata = wb_sel ? line_data : wdata_q;
	end

endmodule

`default_nettype wire

/* l1_tag_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_consts.svh"

module l1_tag_store (
	input  wire                          clk,
	input  wire                          rst,
	input  wire l1_cache_pkg::index_t      index,
	input  wire l1_cache_pkg::tag_t        req_tag,
	input  wire l1_cache_pkg::array_ctrl_t ctrl,
	output l1_cache_pkg::lookup_t        lookup,
	output l1_cache_pkg::tag_t           victim_tag
);

	logic [`L1_LINES-1:0] valid_q;
	logic [`L1_LINES-1:0] dirty_q;
	l1_cache_pkg::tag_t   tag_mem [`L1_LINES];

	// Valid and dirty bits per line.
	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			valid_q <= '0;
			dirty_q <= '0;
		end
		else if (ctrl.tag_we)
		begin
			valid_q[index] <= 1'b1;
			dirty_q[index] <= ctrl.dirty_o;
		end
	end

	always_ff @(posedge clk)
	begin
		if (ctrl.tag_we)
			tag_mem[index] <= req_tag;
	end

	// Hit is a plain tag match; the controller qualifies it with valid.
	always_comb
	begin
		lookup.hit   = (tag_mem[index] == req_tag);
		lookup.valid = valid_q[index];
		lookup.dirty = dirty_q[index];
	end

	// Stored tag of the current line, for the write-back address.
	assign victim_tag = tag_mem[index];

endmodule

`default_nettype wire

/* l1_data_store.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_consts.svh"

module l1_data_store (
	input  wire                          clk,
	input  wire l1_cache_pkg::index_t      index,
	input  wire l1_cache_pkg::array_ctrl_t ctrl,
	input  wire l1_cache_pkg::word_t       cpu_wdata,
	input  wire l1_cache_pkg::word_t       dram_rdata,
	output l1_cache_pkg::word_t          line_data
);

	l1_cache_pkg::word_t data_mem [`L1_LINES];
	l1_cache_pkg::word_t wr_word;

	// A fill takes the DRAM word, a write hit the CPU word.
	assign wr_word = ctrl.fill ? dram_rdata : cpu_wdata;

	always_ff @(posedge clk)
	begin
		if (ctrl.sram_we)
			data_mem[index] <= wr_word;
	end

	// Asynchronous read of the indexed line.
	assign line_data = data_mem[index];

endmodule

`default_nettype wire

/* l1_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache (
	input  wire                        clk,
	input  wire                        rst,
	input  wire l1_cache_pkg::cpu_req_t  cpu_req,
	output logic                       ack,
	output l1_cache_pkg::word_t        rdata,
	output l1_cache_pkg::dram_req_t    dram_req,
	input  wire                        dram_ack,
	input  wire l1_cache_pkg::word_t     dram_rdata
);

	l1_cache_pkg::index_t      index;
	l1_cache_pkg::tag_t        req_tag;
	l1_cache_pkg::tag_t        victim_tag;
	l1_cache_pkg::lookup_t     lookup;
	l1_cache_pkg::word_t       line_data;
	l1_cache_pkg::array_ctrl_t ctrl;

	l1_cache_controller u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.cpu_req    (cpu_req),
		.ack        (ack),
		.rdata      (rdata),
		.index      (index),
		.req_tag    (req_tag),
		.lookup     (lookup),
		.victim_tag (victim_tag),
		.line_data  (line_data),
		.ctrl       (ctrl),
		.dram_req   (dram_req),
		.dram_ack   (dram_ack),
		.dram_rdata (dram_rdata)
	);

	l1_tag_store u_tags (
		.clk        (clk),
		.rst        (rst),
		.index      (index),
		.req_tag    (req_tag),
		.ctrl       (ctrl),
		.lookup     (lookup),
		.victim_tag (victim_tag)
	);

	// The fill word is the controller's registered copy of the DRAM data.
	l1_data_store u_data (
		.clk        (clk),
		.index      (index),
		.ctrl       (ctrl),
		.cpu_wdata  (cpu_req.wdata),
		.dram_rdata (rdata),
		.line_data  (line_data)
	);

endmodule

`default_nettype wire

/* l1_cache_clkgen.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_clkgen (
	output logic clk,
	output logic rst
);

	// 40 ns clock period.
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Active-low reset held for the first 16 rising edges.
	initial
	begin
		rst = 1'b0;
		repeat (16) @(posedge clk);
		#2 rst = 1'b1;
	end

endmodule

`default_nettype wire

/* l1_cache_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module l1_cache_sva (
	input wire                          clk,
	input wire                          rst,
	input wire                          ack,
	input wire l1_cache_pkg::dram_req_t dram_req,
	input wire                          dram_ack
);

	// Number of failed assertions so far.
	int violations = 0;

	// Ack is a single-cycle pulse.
	ack_pulse: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack)
	else
	begin
		$error("ack high for more than one cycle");
		violations++;
	end

	// A DRAM request stays up until DRAM answers it.
	dram_cs_held: assert property (@(posedge clk) disable iff (!rst)
		dram_req.cs && !dram_ack |=> dram_req.cs)
	else
	begin
		$error("dram cs dropped before dram_ack");
		violations++;
	end

	// Address, write enable and data do not move while waiting.
	dram_req_stable: assert property (@(posedge clk) disable iff (!rst)
		dram_req.cs && !dram_ack |=> $stable(dram_req))
	else
	begin
		$error("dram request changed while waiting for dram_ack");
		violations++;
	end

	// Nothing is requested or acknowledged right after a reset edge.
	quiet_after_reset: assert property (@(posedge clk) !rst |=> !ack && !dram_req.cs)
	else
	begin
		$error("ack or dram cs high after reset");
		violations++;
	end

endmodule

bind l1_cache l1_cache_sva u_sva (
	.clk      (clk),
	.rst      (rst),
	.ack      (ack),
	.dram_req (dram_req),
	.dram_ack (dram_ack)
);

`default_nettype wire

/* l1_cache_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "l1_cache_consts.svh"

module l1_cache_tb;

	localparam int clk_period_ns = 40;
	// Generous bound on one request, write-back and two slow DRAM accesses included.
	localparam int cycles_per_test = 32;

	typedef struct packed {
		logic                we;
		l1_cache_pkg::addr_t addr;
		l1_cache_pkg::word_t wdata;
		l1_cache_pkg::word_t rdata;
		int                  exp_reads;
		int                  exp_writes;
		l1_cache_pkg::addr_t waddr;
	} test_t;

	logic                    clk;
	logic                    rst;
	l1_cache_pkg::cpu_req_t  cpu_req;
	logic                    ack;
	l1_cache_pkg::word_t     rdata;
	l1_cache_pkg::dram_req_t dram_req;
	logic                    dram_ack;
	l1_cache_pkg::word_t     dram_rdata;

	l1_cache_pkg::word_t dram_mem [1 << `L1_ADDR_W];
	test_t               tests [$];
	int                  errors;
	int                  dram_reads;
	int                  dram_writes;
	l1_cache_pkg::addr_t last_waddr;
	int                  limit_ns;

	l1_cache_clkgen clkgen0 (
		.clk (clk),
		.rst (rst)
	);

	l1_cache dut0 (
		.clk        (clk),
		.rst        (rst),
		.cpu_req    (cpu_req),
		.ack        (ack),
		.rdata      (rdata),
		.dram_req   (dram_req),
		.dram_ack   (dram_ack),
		.dram_rdata (dram_rdata)
	);

	// Power-up DRAM word: the address above, its inverse below.
	function automatic l1_cache_pkg::word_t dram_init_word(input l1_cache_pkg::addr_t a);
		return {a, ~a};
	endfunction

	task automatic check_word(input string name, input l1_cache_pkg::word_t got,
		input l1_cache_pkg::word_t expected);
		if (got !== expected)
		begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input l1_cache_pkg::addr_t got,
		input l1_cache_pkg::addr_t expected);
		if (got !== expected)
		begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, expected);
			errors++;
		end
	endtask

	task automatic load_tests();
		int                  fd;
		string               line;
		int                  op;
		int                  n_rd;
		int                  n_wr;
		l1_cache_pkg::addr_t addr;
		l1_cache_pkg::addr_t waddr;
		l1_cache_pkg::word_t wdata;
		l1_cache_pkg::word_t exp_rdata;
		test_t               t;
		fd = $fopen("l1_cache_tests.txt", "r");
		if (fd == 0)
		begin
			$display("could not open l1_cache_tests.txt");
			errors++;
		end
		else
		begin
			while ($fgets(line, fd) > 0)
			begin
				// Comment and blank lines do not convert and are skipped.
				if ($sscanf(line, "%h %h %h %h %d %d %h", op, addr, wdata, exp_rdata,
					n_rd, n_wr, waddr) == 7)
				begin
					t.we = (op != 0);
					t.addr = addr;
					t.wdata = wdata;
					t.rdata = exp_rdata;
					t.exp_reads = n_rd;
					t.exp_writes = n_wr;
					t.waddr = waddr;
					tests.push_back(t);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_test(input int i);
		test_t t;
		int    edges;
		int    errs_before;
		int    reads_before;
		int    writes_before;
		t = tests[i];
		errs_before = errors;
		reads_before = dram_reads;
		writes_before = dram_writes;
		cpu_req.we = t.we;
		cpu_req.addr = t.addr;
		cpu_req.wdata = t.wdata;
		cpu_req.cs = 1'b1;
		edges = 0;
		do
		begin
			@(posedge clk);
			#2;
			edges++;
		end
		while (!ack);
		// Only cs drops; a write hit still takes its data in the next edge.
		cpu_req.cs = 1'b0;
		if (!t.we)
			check_word("rdata", rdata, t.rdata);
		if ((dram_reads - reads_before) != t.exp_reads ||
			(dram_writes - writes_before) != t.exp_writes)
		begin
			$display("test %0d: DRAM saw %0d reads and %0d writes, expected %0d and %0d",
				i + 1, dram_reads - reads_before, dram_writes - writes_before,
				t.exp_reads, t.exp_writes);
			errors++;
		end
		else if (t.exp_writes > 0)
			check_addr("dram_req.addr", last_waddr, t.waddr);
		if (t.exp_reads == 0 && t.exp_writes == 0 && edges != 2)
		begin
			$display("test %0d: hit answered after %0d edges instead of 2", i + 1, edges);
			errors++;
		end
		@(posedge clk);
		#2;
		$display("test %0d %s %h %s", i + 1, t.we ? "write" : "read", t.addr,
			(errors == errs_before) ? "ok" : "bad");
	endtask

	// DRAM model with a random 1 to 6 cycle answer.
	initial
	begin : dram_model
		int delay;
		void'($urandom(18043));
		dram_ack = 1'b0;
		dram_rdata = '0;
		dram_reads = 0;
		dram_writes = 0;
		last_waddr = '0;
		for (int a = 0; a < (1 << `L1_ADDR_W); a++)
			dram_mem[a] = dram_init_word(l1_cache_pkg::addr_t'(a));
		forever
		begin
			@(posedge clk);
			#2;
			dram_ack = 1'b0;
			if (dram_req.cs)
			begin
				delay = 1 + ($urandom % 6);
				repeat (delay - 1)
				begin
					@(posedge clk);
					#2;
				end
				if (dram_req.we)
				begin
					dram_mem[dram_req.addr] = dram_req.wdata;
					last_waddr = dram_req.addr;
					dram_writes++;
				end
				else
				begin
					dram_rdata = dram_mem[dram_req.addr];
					dram_reads++;
				end
				dram_ack = 1'b1;
			end
		end
	end

	initial
	begin : watchdog
		wait (limit_ns > 0);
		#(limit_ns);
		$display("watchdog: the run did not finish within %0d ns", limit_ns);
		$display("tests failed");
		$finish;
	end

	initial
	begin : main
		errors = 0;
		limit_ns = 0;
		cpu_req = '0;
		load_tests();
		limit_ns = (20 + tests.size() * cycles_per_test) * clk_period_ns;
		if (tests.size() == 0)
		begin
			$display("no tests found in l1_cache_tests.txt");
			errors++;
		end
		wait (rst === 1'b1);
		@(posedge clk);
		#2;
		for (int i = 0; i < tests.size(); i++)
			run_test(i);
		$display("ran %0d tests with %0d errors and %0d assertion failures",
			tests.size(), errors, dut0.u_sva.violations);
		if (errors == 0 && dut0.u_sva.violations == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

/* l1_cache_tests.txt */
# op (0 read, 1 write), addr, wdata, expected rdata, DRAM reads, DRAM writes,
# expected address of the last DRAM write; all hex except the two counts
0 0013 00000000 0013ffec 1 0 0000
0 0013 00000000 0013ffec 0 0 0000
1 0013 cafe0001 00000000 0 0 0000
0 0013 00000000 cafe0001 0 0 0000
0 0123 00000000 0123fedc 1 1 0013
0 0013 00000000 cafe0001 1 0 0000
1 0457 12345678 00000000 0 1 0457
0 0457 00000000 12345678 1 0 0000
0 0457 00000000 12345678 0 0 0000
1 0013 beef0002 00000000 0 0 0000
1 0023 0badf00d 00000000 0 1 0023
0 0013 00000000 beef0002 0 0 0000
0 0023 00000000 0badf00d 1 1 0013
0 0013 00000000 beef0002 1 0 0000
0 ffff 00000000 ffff0000 1 0 0000
0 0000 00000000 0000ffff 1 0 0000
1 0000 aaaa5555 00000000 0 0 0000
0 1000 00000000 1000efff 1 1 0000
0 0000 00000000 aaaa5555 1 0 0000
0 ffff 00000000 ffff0000 0 0 0000
0 8ac5 00000000 8ac5753a 1 0 0000
1 8ac5 01020304 00000000 0 0 0000
1 8ac5 05060708 00000000 0 0 0000
0 8ac5 00000000 05060708 0 0 0000
0 9ac5 00000000 9ac5653a 1 1 8ac5
0 8ac5 00000000 05060708 1 0 0000
1 7777 11112222 00000000 0 1 7777
0 0457 00000000 12345678 0 0 0000
0 7777 00000000 11112222 1 0 0000
0 0457 00000000 12345678 1 0 0000

/* l1_cache.f */
+incdir+.
l1_cache_pkg.sv
l1_cache_controller.sv
l1_tag_store.sv
l1_data_store.sv
l1_cache.sv
l1_cache_clkgen.sv
l1_cache_sva.sv
l1_cache_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the l1_cache testbench with Verilator.
# The exit status is zero only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module l1_cache_tb -f l1_cache.f -o l1_cache_sim \
	&& ./obj_dir/l1_cache_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "all tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
